//--- Bender.yml
package:
  name: enc8b10b_tx

sources:
  - logic/enc_pkg.sv
  - logic/sym_if.sv
  - logic/frame_sequencer.sv
  - logic/symbol_encoder.sv
  - logic/enc8b10b_tx.sv
  - target: test
    files:
      - test/enc8b10b_tx_asserts.sv
      - test/enc8b10b_tx_tb.sv

//--- enc8b10b_tx.f
logic/enc_pkg.sv
logic/sym_if.sv
logic/frame_sequencer.sv
logic/symbol_encoder.sv
logic/enc8b10b_tx.sv
test/enc8b10b_tx_asserts.sv
test/enc8b10b_tx_tb.sv

//--- logic/enc8b10b_tx.sv
`timescale 1ns/1ns
`default_nettype none

module enc8b10b_tx #(
	parameter int preamble_len = enc_pkg::preamble_len_default
) (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic [enc_pkg::sym_width-1:0] datain,
	input logic startin,
	output logic pushout,
	output logic [enc_pkg::code_width-1:0] dataout,
	output logic startout
);
	sym_if sym (); // Sequencer to encoder, one symbol per strobe

	frame_sequencer #(
		.preamble_len(preamble_len)
	) seq_inst (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.datain(datain),
		.startin(startin),
		.sym(sym.issuer)
	);

	symbol_encoder enc_inst (
		.clk(clk),
		.reset(reset),
		.sym(sym.encoder),
		.pushout(pushout),
		.dataout(dataout),
		.startout(startout)
	);
endmodule

`default_nettype wire

//--- logic/enc_pkg.sv
`default_nettype none

package enc_pkg;

	parameter int sym_width = 9; // K flag plus byte
	parameter int code_width = 10; // Encoded word
	parameter int preamble_len_default = 4; // K28.1 count per frame start

	parameter logic [7:0] k28_1_byte = 8'h3C; // Preamble symbol
	parameter logic [7:0] k28_5_byte = 8'hBC; // End marker and trailer
	parameter logic [7:0] k23_7_byte = 8'hF7; // Replaces the end marker

	typedef enum logic [1:0] {
		idle, // Waiting for frame start
		preamble, // Taking remaining K28.1 symbols
		payload, // Passing data and control
		trailer // Issuing K28.5 alone
	} seq_state_t;

	// 5b/6b sub-block, abcdei with a first
	// rd is 0 for RD- and 1 for RD+
	function automatic logic [5:0] encode_6b(input logic [4:0] x, input logic rd);
		logic [5:0] code;
		case (x)
			5'd0: code = 6'b100111; // RD- forms throughout
			5'd1: code = 6'b011101;
			5'd2: code = 6'b101101;
			5'd3: code = 6'b110001;
			5'd4: code = 6'b110101;
			5'd5: code = 6'b101001;
			5'd6: code = 6'b011001;
			5'd7: code = 6'b111000; // Balanced but still two forms
			5'd8: code = 6'b111001;
			5'd9: code = 6'b100101;
			5'd10: code = 6'b010101;
			5'd11: code = 6'b110100;
			5'd12: code = 6'b001101;
			5'd13: code = 6'b101100;
			5'd14: code = 6'b011100;
			5'd15: code = 6'b010111;
			5'd16: code = 6'b011011;
			5'd17: code = 6'b100011;
			5'd18: code = 6'b010011;
			5'd19: code = 6'b110010;
			5'd20: code = 6'b001011;
			5'd21: code = 6'b101010;
			5'd22: code = 6'b011010;
			5'd23: code = 6'b111010;
			5'd24: code = 6'b110011;
			5'd25: code = 6'b100110;
			5'd26: code = 6'b010110;
			5'd27: code = 6'b110110;
			5'd28: code = 6'b001110;
			5'd29: code = 6'b101110;
			5'd30: code = 6'b011110;
			default: code = 6'b101011; // D.31
		endcase
		// RD+ form is the complement for unbalanced codes and D.7
		if (rd && (($countones(code) != 3) || (x == 5'd7)))
			code = ~code;
		return code;
	endfunction

	// 3b/4b sub-block, fghj with f first
	// rd is the disparity left after the 6b sub-block
	function automatic logic [3:0] encode_4b(
		input logic [2:0] y,
		input logic [4:0] x,
		input logic rd
	);
		logic [3:0] code;
		logic alt;
		alt = (y == 3'd7) && // A7 avoids a run of five
			((!rd && ((x == 5'd17) || (x == 5'd18) || (x == 5'd20))) ||
			(rd && ((x == 5'd11) || (x == 5'd13) || (x == 5'd14))));
		case (y)
			3'd0: code = 4'b1011; // RD- forms throughout
			3'd1: code = 4'b1001;
			3'd2: code = 4'b0101;
			3'd3: code = 4'b1100; // Balanced but still two forms
			3'd4: code = 4'b1101;
			3'd5: code = 4'b1010;
			3'd6: code = 4'b0110;
			default: code = alt ? 4'b0111 : 4'b1110; // A7 or P7
		endcase
		if (rd && (($countones(code) != 2) || (y == 3'd3)))
			code = ~code;
		return code;
	endfunction

endpackage

`default_nettype wire

//--- logic/frame_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_sequencer #(
	parameter int preamble_len = enc_pkg::preamble_len_default
) (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic [enc_pkg::sym_width-1:0] datain,
	input logic startin,
	sym_if.issuer sym
);
	localparam int cnt_width = $clog2(preamble_len) + 1;
	localparam logic [cnt_width-1:0] last_cnt = cnt_width'(preamble_len - 1);

	enc_pkg::seq_state_t state; // Frame position
	enc_pkg::seq_state_t state_next;
	logic [cnt_width-1:0] cnt; // Preamble symbols taken so far
	logic [cnt_width-1:0] cnt_next;
	logic is_k28_1;
	logic is_k28_5;

	assign is_k28_1 = (datain == {1'b1, enc_pkg::k28_1_byte}); // Preamble symbol
	assign is_k28_5 = (datain == {1'b1, enc_pkg::k28_5_byte}); // End marker

	always_comb begin
		state_next = state;
		cnt_next = cnt;
		sym.valid = 1'b0;
		sym.k = datain[enc_pkg::sym_width-1]; // Pass-through by default
		sym.value = datain[enc_pkg::sym_width-2:0];
		sym.first = 1'b0;
		case (state)
			enc_pkg::idle: begin
				if (pushin && startin && is_k28_1) begin // Frame start
					sym.valid = 1'b1;
					sym.first = 1'b1;
					cnt_next = cnt_width'(1);
					if (preamble_len > 1)
						state_next = enc_pkg::preamble;
					else
						state_next = enc_pkg::payload; // Single-symbol preamble
				end
			end
			enc_pkg::preamble: begin
				if (pushin) begin
					if (is_k28_1) begin
						sym.valid = 1'b1;
						cnt_next = cnt + 1'b1;
						if (cnt == last_cnt) // Last one
							state_next = enc_pkg::payload;
					end else begin
						state_next = enc_pkg::idle; // Bad preamble, drop it
					end
				end
			end
			enc_pkg::payload: begin
				if (pushin) begin
					sym.valid = 1'b1;
					if (is_k28_5) begin // End of frame
						sym.value = enc_pkg::k23_7_byte;
						state_next = enc_pkg::trailer;
					end
				end
			end
			enc_pkg::trailer: begin
				sym.valid = 1'b1; // Input here is dropped
				sym.k = 1'b1;
				sym.value = enc_pkg::k28_5_byte;
				state_next = enc_pkg::idle;
			end
			default: begin
				state_next = enc_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= enc_pkg::idle;
			cnt <= '0;
		end else begin
			state <= state_next;
			cnt <= cnt_next;
		end
	end
endmodule

`default_nettype wire

//--- logic/sym_if.sv
`timescale 1ns/1ns
`default_nettype none

interface sym_if;
	logic valid; // One-cycle strobe, no handshake
	logic k; // Control symbol
	logic [7:0] value; // Byte to encode
	logic first; // First preamble symbol only

	modport issuer (
		output valid, k, value, first
	);

	modport encoder (
		input valid, k, value, first
	);
endinterface

`default_nettype wire

//--- logic/symbol_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module symbol_encoder (
	input logic clk,
	input logic reset,
	sym_if.encoder sym,
	output logic pushout,
	output logic [enc_pkg::code_width-1:0] dataout,
	output logic startout
);
	logic rd; // Running disparity, 0 is RD-
	logic [5:0] d6;
	logic rd6; // Disparity after 6b sub-block
	logic [3:0] d4;
	logic [enc_pkg::code_width-1:0] k_word; // RD- form of control word
	logic k_ok; // Supported control byte
	logic [enc_pkg::code_width-1:0] word;
	logic word_ok;

	always_comb begin
		d6 = enc_pkg::encode_6b(sym.value[4:0], rd);
		rd6 = rd ^ ($countones(d6) != 3);
		d4 = enc_pkg::encode_4b(sym.value[7:5], sym.value[4:0], rd6);
	end

	// Control words, RD+ form is the complement
	always_comb begin
		k_ok = 1'b1;
		case (sym.value)
			8'h1C: k_word = 10'b0011110100; // K28.0
			enc_pkg::k28_1_byte: k_word = 10'b0011111001; // K28.1
			8'h5C: k_word = 10'b0011110101; // K28.2
			8'h7C: k_word = 10'b0011110011; // K28.3
			8'h9C: k_word = 10'b0011110010; // K28.4
			enc_pkg::k28_5_byte: k_word = 10'b0011111010; // K28.5
			8'hDC: k_word = 10'b0011110110; // K28.6
			8'hFC: k_word = 10'b0011111000; // K28.7
			enc_pkg::k23_7_byte: k_word = 10'b1110101000; // K23.7
			8'hFB: k_word = 10'b1101101000; // K27.7
			8'hFD: k_word = 10'b1011101000; // K29.7
			8'hFE: k_word = 10'b0111101000; // K30.7
			default: begin
				k_word = '0;
				k_ok = 1'b0; // Not in table, no word
			end
		endcase
	end

	always_comb begin
		if (sym.k) begin
			word = rd ? ~k_word : k_word;
			word_ok = k_ok;
		end else begin
			word = {d6, d4}; // 6b first, MSB first
			word_ok = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pushout <= 1'b0;
			startout <= 1'b0;
			rd <= 1'b0; // Start at RD-
		end else begin
			pushout <= sym.valid && word_ok;
			startout <= sym.valid && word_ok && sym.first;
			if (sym.valid && word_ok)
				rd <= rd ^ ($countones(word) != 5); // Flip on unbalanced word
		end
	end

	always_ff @(posedge clk) begin
		if (sym.valid && word_ok)
			dataout <= word;
	end
endmodule

`default_nettype wire

//--- test/enc8b10b_tx_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module enc8b10b_tx_asserts (
	input logic clk,
	input logic reset,
	input logic pushout,
	input logic [9:0] dataout,
	input logic startout
);
	logic have_last; // An unbalanced word seen since reset
	logic last_plus; // Its excess was ones

	always_ff @(posedge clk) begin
		if (reset) begin
			have_last <= 1'b0;
			last_plus <= 1'b0;
		end else if (pushout && ($countones(dataout) != 5)) begin
			have_last <= 1'b1;
			last_plus <= ($countones(dataout) == 6);
		end
	end

	start_needs_push: assert property (@(posedge clk) disable iff (reset)
		startout |-> pushout) else $error("startout without pushout");

	ones_in_range: assert property (@(posedge clk) disable iff (reset)
		pushout |-> ($countones(dataout) >= 4 && $countones(dataout) <= 6))
		else $error("dataout ones count out of range");

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !pushout) else $error("pushout high after reset cycle");

	// Unbalanced words must alternate their excess
	excess_alternates: assert property (@(posedge clk) disable iff (reset)
		(pushout && ($countones(dataout) != 5) && have_last)
		|-> (($countones(dataout) == 6) != last_plus))
		else $error("two unbalanced words with same excess");
endmodule

bind enc8b10b_tx enc8b10b_tx_asserts asserts_inst (
	.clk(clk),
	.reset(reset),
	.pushout(pushout),
	.dataout(dataout),
	.startout(startout)
);

`default_nettype wire

//--- test/enc8b10b_tx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module enc8b10b_tx_tb;
	localparam int max_cycles = 2000; // Tests need about 500
	localparam logic [9:0] k28_1_w = 10'b0011111001; // RD- forms from the standard table
	localparam logic [9:0] k28_5_w = 10'b0011111010;
	localparam logic [9:0] k28_0_w = 10'b0011110100;
	localparam logic [9:0] k27_7_w = 10'b1101101000;
	localparam logic [9:0] k23_7_w = 10'b1110101000;

	logic clk = 1'b0;
	logic reset;
	logic pushin;
	logic [8:0] datain;
	logic startin;
	logic pushout;
	logic [9:0] dataout;
	logic startout;

	int cycles = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int push_cyc;
	int seed = 32'ha0dc;
	logic rd = 1'b0; // Tracked disparity, 0 is RD-
	logic last_bit = 1'b0;
	int run_len = 0;
	logic [9:0] words[$]; // Observed words
	logic starts[$];
	int wcyc[$];

	enc8b10b_tx enc8b10b_tx_inst (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.datain(datain),
		.startin(startin),
		.pushout(pushout),
		.dataout(dataout),
		.startout(startout)
	);

	always #20 clk = ~clk; // 40 ns period

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Run stopped, no finish after %0d cycles", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			if (pushout || startout) begin
				$display("Output strobe seen while reset is high");
				errors = errors + 1;
			end
		end else if (pushout) begin
			words.push_back(dataout);
			starts.push_back(startout);
			wcyc.push_back(cycles);
		end
	end

	task automatic push_sym(input logic k, input logic [7:0] b, input logic st);
		@(negedge clk);
		pushin = 1'b1;
		datain = {k, b};
		startin = st;
		push_cyc = cycles;
	endtask

	task automatic release_bus();
		@(negedge clk);
		pushin = 1'b0;
		startin = 1'b0;
		datain = '0;
	endtask

	// Waits for the next word, lat is its expected distance from the last push
	task automatic fetch(input int lat, output logic [9:0] w, output logic st);
		int n;
		n = 0;
		w = 'x;
		st = 1'b0;
		while (words.size() == 0 && n < 8) begin
			@(posedge clk);
			n = n + 1;
		end
		if (words.size() == 0) begin
			$display("No output word arrived after a push");
			errors = errors + 1;
		end else begin
			w = words.pop_front();
			st = starts.pop_front();
			if (wcyc.pop_front() != push_cyc + lat) begin
				$display("Output word arrived at the wrong cycle");
				errors = errors + 1;
			end
		end
	endtask

	task automatic check_eq(input string name, input logic [9:0] exp, input logic [9:0] got);
		if (got !== exp) begin
			$display("ERROR %s expected %h got %h", name, exp, got);
			errors = errors + 1;
		end
	endtask

	// Disparity and run-length rules, then flip tracked RD
	task automatic track(input logic [9:0] w);
		int ones;
		ones = $countones(w);
		if (ones < 4 || ones > 6 || (ones == 6 && rd) || (ones == 4 && !rd)) begin
			$display("ERROR dataout ones %h for rd %h word %h", ones, rd, w);
			errors = errors + 1;
		end
		for (int i = 9; i >= 0; i--) begin
			run_len = (w[i] == last_bit) ? run_len + 1 : 1;
			last_bit = w[i];
			if (run_len > 5) begin
				$display("ERROR dataout run of %h equal bits in word %h", run_len, w);
				errors = errors + 1;
			end
		end
		if (ones != 5)
			rd = ~rd;
	endtask

	// One symbol, one word with table value exp_m at RD- (complement at RD+)
	task automatic send_k(input logic [7:0] b, input logic st, input logic [9:0] exp_m);
		logic [9:0] w;
		logic s;
		push_sym(1'b1, b, st);
		release_bus();
		fetch(1, w, s);
		check_eq("dataout", rd ? ~exp_m : exp_m, w);
		if (s !== st) begin
			$display("ERROR startout expected %h got %h", st, s);
			errors = errors + 1;
		end
		track(w);
	endtask

	task automatic send_d(input logic [7:0] b, input logic [9:0] exp);
		logic [9:0] w;
		logic s;
		push_sym(1'b0, b, 1'b0);
		release_bus();
		fetch(1, w, s);
		check_eq("dataout", exp, w);
		track(w);
	endtask

	task automatic expect_quiet(input int n);
		repeat (n) @(posedge clk);
		if (words.size() != 0) begin
			$display("A word came out where none was expected");
			errors = errors + 1;
			words.delete();
			starts.delete();
			wcyc.delete();
		end
	endtask

	task automatic preamble();
		for (int i = 0; i < 4; i++)
			send_k(8'h3C, i == 0, k28_1_w); // Alternates from RD-
	endtask

	task automatic end_frame();
		logic [9:0] w;
		logic s;
		logic [9:0] exp23;
		push_sym(1'b1, 8'hBC, 1'b0);
		release_bus();
		exp23 = rd ? ~k23_7_w : k23_7_w;
		fetch(1, w, s);
		check_eq("dataout", exp23, w);
		track(w);
		fetch(2, w, s);
		check_eq("dataout", rd ? ~k28_5_w : k28_5_w, w);
		track(w);
		expect_quiet(3); // pushout low after the trailer
	endtask

	task automatic report(input string name, input int err_before);
		tests_run = tests_run + 1;
		if (errors == err_before) begin
			$display("%s: pass", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("%s: fail", name);
		end
	endtask

	task automatic idle_test();
		int e;
		e = errors;
		push_sym(1'b1, 8'h3C, 1'b0); // K28.1 without startin
		push_sym(1'b0, 8'h3C, 1'b1); // Data with startin
		push_sym(1'b1, 8'hBC, 1'b1);
		release_bus();
		expect_quiet(4);
		report("idle silence", e);
	endtask

	task automatic preamble_test();
		int e;
		e = errors;
		preamble();
		if (rd !== 1'b0) begin
			$display("Disparity is not RD- after the preamble");
			errors = errors + 1;
		end
		report("preamble", e);
	endtask

	task automatic data_test();
		int e;
		e = errors;
		send_d(8'h00, 10'b1001110100); // D0.0, stays RD-
		send_d(8'hB5, 10'b1010101010); // D21.5
		send_d(8'h07, 10'b1110001011); // D7.0 moves to RD+
		send_d(8'hEB, 10'b1101001000); // D11.7 alternate form at RD+
		report("known data codes", e);
	endtask

	task automatic random_test();
		int e;
		logic [9:0] w;
		logic s;
		e = errors;
		for (int i = 0; i < 40; i++)
			push_sym(1'b0, 8'($random(seed)), 1'b0);
		release_bus();
		for (int i = 0; i < 40; i++) begin
			fetch(i - 38, w, s); // Pushes were back to back
			track(w);
		end
		report("random payload disparity", e);
	endtask

	task automatic control_test();
		int e;
		e = errors;
		send_k(8'h1C, 1'b0, k28_0_w);
		send_k(8'hFB, 1'b0, k27_7_w);
		end_frame();
		report("control codes and trailer", e);
	endtask

	task automatic error_test();
		int e;
		e = errors;
		send_k(8'h3C, 1'b1, k28_1_w);
		push_sym(1'b0, 8'h21, 1'b0); // Data in the preamble
		push_sym(1'b1, 8'h3C, 1'b0); // Back in idle, ignored
		release_bus();
		expect_quiet(4);
		preamble();
		push_sym(1'b1, 8'h00, 1'b0); // Not a control code
		release_bus();
		expect_quiet(4);
		send_k(8'h1C, 1'b0, k28_0_w); // Same disparity as before the drop
		end_frame();
		report("error paths", e);
	endtask

	initial begin
		reset = 1'b1;
		pushin = 1'b0;
		datain = '0;
		startin = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		idle_test();
		preamble_test();
		data_test();
		random_test();
		control_test();
		error_test();
		$display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end
endmodule

`default_nettype wire
